/* verilog/tnn_cfg_pkg.sv */
`default_nettype none

package tnn_cfg_pkg;

    localparam int N_FEAT = 11;
    localparam int N_HID = 40;
    localparam int N_CLASS = 6;

    localparam int Q_BITS = 4;
    localparam int RAW_BITS = 8;
    localparam int HSUM_BITS = $clog2(N_FEAT + 1) + Q_BITS; // Worst case is all features at max
    localparam int SCORE_BITS = $clog2(N_HID + 1);
    localparam int CLASS_BITS = 3;

    typedef logic [RAW_BITS-1:0] raw_feat_t;
    typedef logic [Q_BITS-1:0] q_feat_t;
    typedef logic [SCORE_BITS-1:0] score_t;
    typedef score_t [N_CLASS-1:0] score_vec_t;

    // Feature 0 sits in the lowest slot of both vectors
    typedef struct packed {
        raw_feat_t [N_FEAT-1:0] feat;
    } raw_sample_t;

    typedef struct packed {
        q_feat_t [N_FEAT-1:0] feat;
    } feature_vec_t;

    typedef struct packed {
        logic [CLASS_BITS-1:0] class_idx;
        score_t                score;
    } class_result_t;

    typedef enum logic [1:0] {
        CLS_IDLE,
        CLS_ACCUM,
        CLS_DECIDE
    } cls_state_t;

endpackage

`default_nettype wire

/* verilog/tnn_weights_pkg.sv */
`default_nettype none

package tnn_weights_pkg;

    import tnn_cfg_pkg::*;

    typedef logic signed [1:0] tern_t;

    localparam tern_t POS = 2'sb01;
    localparam tern_t NEG = 2'sb11;
    localparam tern_t ZRO = 2'sb00;

    // One row per hidden neuron, one entry per feature
    localparam tern_t hid_weight [N_HID][N_FEAT] = '{
        '{NEG, NEG, POS, NEG, NEG, POS, NEG, NEG, ZRO, POS, ZRO},
        '{NEG, ZRO, ZRO, NEG, ZRO, NEG, POS, ZRO, POS, ZRO, NEG},
        '{ZRO, ZRO, ZRO, ZRO, ZRO, ZRO, ZRO, ZRO, ZRO, ZRO, ZRO},
        '{ZRO, ZRO, ZRO, ZRO, POS, NEG, POS, ZRO, POS, ZRO, NEG},
        '{ZRO, POS, POS, ZRO, POS, NEG, ZRO, NEG, NEG, NEG, NEG},
        '{NEG, POS, POS, ZRO, ZRO, POS, POS, NEG, NEG, POS, ZRO},
        '{ZRO, ZRO, ZRO, ZRO, ZRO, ZRO, ZRO, ZRO, ZRO, ZRO, ZRO},
        '{NEG, ZRO, POS, ZRO, NEG, NEG, NEG, POS, ZRO, ZRO, POS},
        '{NEG, POS, POS, POS, POS, ZRO, POS, ZRO, ZRO, NEG, NEG},
        '{POS, POS, POS, POS, ZRO, NEG, ZRO, ZRO, ZRO, ZRO, POS},
        '{ZRO, NEG, NEG, ZRO, ZRO, ZRO, NEG, NEG, ZRO, POS, ZRO},
        '{ZRO, NEG, NEG, ZRO, ZRO, NEG, NEG, NEG, ZRO, ZRO, POS},
        '{ZRO, POS, NEG, ZRO, ZRO, NEG, ZRO, NEG, ZRO, NEG, POS},
        '{POS, NEG, POS, ZRO, ZRO, POS, POS, ZRO, POS, NEG, POS},
        '{ZRO, POS, POS, POS, NEG, POS, POS, POS, ZRO, ZRO, ZRO},
        '{ZRO, POS, ZRO, ZRO, ZRO, ZRO, POS, ZRO, NEG, NEG, ZRO},
        '{ZRO, NEG, NEG, NEG, ZRO, NEG, ZRO, POS, NEG, ZRO, POS},
        '{POS, ZRO, POS, ZRO, NEG, NEG, POS, ZRO, ZRO, POS, NEG},
        '{ZRO, ZRO, POS, ZRO, NEG, POS, POS, POS, POS, ZRO, POS},
        '{NEG, ZRO, ZRO, ZRO, ZRO, POS, NEG, POS, NEG, NEG, POS},
        '{NEG, ZRO, NEG, ZRO, ZRO, ZRO, ZRO, POS, ZRO, POS, ZRO},
        '{NEG, ZRO, ZRO, POS, NEG, POS, ZRO, ZRO, NEG, NEG, NEG},
        '{POS, NEG, ZRO, ZRO, POS, ZRO, POS, ZRO, ZRO, POS, POS},
        '{POS, NEG, POS, NEG, NEG, POS, NEG, ZRO, POS, ZRO, ZRO},
        '{ZRO, ZRO, POS, NEG, POS, POS, ZRO, POS, NEG, NEG, NEG},
        '{ZRO, NEG, ZRO, POS, ZRO, POS, NEG, ZRO, NEG, ZRO, POS},
        '{POS, NEG, POS, POS, NEG, POS, ZRO, NEG, POS, NEG, NEG},
        '{POS, ZRO, NEG, ZRO, POS, ZRO, NEG, ZRO, ZRO, ZRO, POS},
        '{ZRO, POS, POS, ZRO, ZRO, ZRO, NEG, POS, ZRO, NEG, ZRO},
        '{POS, POS, NEG, ZRO, POS, ZRO, POS, ZRO, ZRO, NEG, ZRO},
        '{POS, ZRO, POS, ZRO, ZRO, NEG, NEG, NEG, POS, NEG, POS},
        '{ZRO, NEG, ZRO, POS, ZRO, ZRO, ZRO, POS, ZRO, NEG, NEG},
        '{POS, NEG, POS, POS, ZRO, POS, ZRO, NEG, POS, ZRO, POS},
        '{NEG, ZRO, NEG, NEG, NEG, ZRO, POS, ZRO, ZRO, POS, POS},
        '{POS, ZRO, NEG, ZRO, ZRO, ZRO, POS, ZRO, NEG, NEG, NEG},
        '{POS, ZRO, NEG, NEG, ZRO, POS, NEG, NEG, NEG, POS, ZRO},
        '{POS, NEG, ZRO, POS, POS, NEG, ZRO, NEG, ZRO, ZRO, ZRO},
        '{ZRO, ZRO, ZRO, ZRO, ZRO, ZRO, ZRO, ZRO, ZRO, ZRO, ZRO},
        '{POS, POS, ZRO, POS, POS, ZRO, POS, POS, NEG, ZRO, ZRO},
        '{ZRO, ZRO, NEG, ZRO, ZRO, POS, POS, POS, NEG, NEG, NEG}
    };

    // One row per class, ten hidden neurons per line
    localparam tern_t out_weight [N_CLASS][N_HID] = '{
        '{NEG, ZRO, POS, NEG, POS, ZRO, ZRO, ZRO, ZRO, ZRO,
          ZRO, ZRO, NEG, ZRO, ZRO, ZRO, ZRO, NEG, NEG, ZRO,
          ZRO, ZRO, POS, NEG, ZRO, ZRO, NEG, ZRO, POS, NEG,
          POS, ZRO, ZRO, ZRO, ZRO, ZRO, ZRO, ZRO, ZRO, POS},
        '{ZRO, ZRO, ZRO, ZRO, ZRO, NEG, ZRO, ZRO, ZRO, POS,
          POS, POS, ZRO, POS, ZRO, ZRO, ZRO, ZRO, ZRO, ZRO,
          ZRO, ZRO, ZRO, ZRO, ZRO, ZRO, ZRO, ZRO, NEG, POS,
          ZRO, ZRO, ZRO, ZRO, ZRO, POS, ZRO, ZRO, ZRO, ZRO},
        '{NEG, NEG, ZRO, ZRO, POS, ZRO, ZRO, ZRO, POS, NEG,
          ZRO, ZRO, NEG, POS, POS, ZRO, ZRO, ZRO, ZRO, ZRO,
          ZRO, ZRO, ZRO, ZRO, ZRO, NEG, ZRO, ZRO, ZRO, ZRO,
          ZRO, ZRO, ZRO, POS, ZRO, NEG, ZRO, ZRO, ZRO, ZRO},
        '{ZRO, NEG, ZRO, ZRO, ZRO, ZRO, POS, ZRO, ZRO, ZRO,
          ZRO, ZRO, NEG, ZRO, ZRO, ZRO, ZRO, ZRO, ZRO, ZRO,
          ZRO, ZRO, ZRO, POS, ZRO, ZRO, ZRO, ZRO, ZRO, ZRO,
          ZRO, ZRO, POS, POS, NEG, ZRO, ZRO, ZRO, ZRO, NEG},
        '{NEG, NEG, POS, NEG, ZRO, ZRO, ZRO, POS, ZRO, ZRO,
          ZRO, POS, NEG, ZRO, POS, NEG, ZRO, ZRO, ZRO, ZRO,
          NEG, ZRO, POS, ZRO, ZRO, NEG, ZRO, ZRO, ZRO, NEG,
          ZRO, NEG, POS, POS, ZRO, ZRO, POS, POS, ZRO, ZRO},
        '{NEG, ZRO, ZRO, ZRO, NEG, ZRO, POS, ZRO, NEG, ZRO,
          ZRO, ZRO, NEG, POS, NEG, ZRO, ZRO, ZRO, ZRO, ZRO,
          ZRO, ZRO, ZRO, ZRO, ZRO, POS, ZRO, ZRO, ZRO, ZRO,
          POS, ZRO, ZRO, POS, ZRO, POS, ZRO, POS, ZRO, ZRO}
    };

    localparam raw_feat_t feat_offset [N_FEAT] = '{
        8'd40, 8'd24, 8'd0, 8'd12, 8'd20, 8'd8,
        8'd16, 8'd48, 8'd30, 8'd10, 8'd64
    };

endpackage

`default_nettype wire

/* verilog/feature_quantizer.sv */
`default_nettype none

module feature_quantizer
    import tnn_cfg_pkg::*;
    import tnn_weights_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  raw_sample_t  sample_in,
    input  logic         sample_valid,
    output feature_vec_t vec_out,
    output logic         vec_valid
);

    localparam int SHIFT = RAW_BITS - Q_BITS;

    feature_vec_t q_next;

    function automatic q_feat_t quantize(input raw_feat_t raw, input raw_feat_t off);
        logic [RAW_BITS:0]   diff;
        logic [RAW_BITS-1:0] sat;
        diff = {1'b0, raw} - {1'b0, off};
        sat = diff[RAW_BITS] ? '0 : diff[RAW_BITS-1:0]; // Borrow means below the offset
        return q_feat_t'(sat >> SHIFT);
    endfunction

    always_comb begin
        for (int f = 0; f < N_FEAT; f++) begin
            q_next.feat[f] = quantize(sample_in.feat[f], feat_offset[f]);
        end
    end

    always_ff @(posedge clk) begin
        if (sample_valid) begin
            vec_out <= q_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vec_valid <= 1'b0;
        end else begin
            vec_valid <= sample_valid;
        end
    end

endmodule

`default_nettype wire

/* verilog/vector_fifo.sv */
`default_nettype none

module vector_fifo
    import tnn_cfg_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         push,
    input  feature_vec_t din,
    input  logic         pop,
    output feature_vec_t dout,
    output logic         empty,
    output logic         overflow
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    feature_vec_t mem [DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic full;
    logic do_push;
    logic do_pop;

    assign full = (count == CNT_BITS'(DEPTH));
    assign empty = (count == '0);
    assign do_push = push && !full; // Full at push time drops the vector
    assign do_pop = pop && !empty;
    assign dout = mem[rd_ptr];

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
            if (push && full) begin
                overflow <= 1'b1; // Sticky until reset
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/argmax.sv */
`default_nettype none

module argmax
    import tnn_cfg_pkg::*;
(
    input  logic          clk,
    input  score_vec_t    scores,
    input  logic          start,
    output class_result_t result,
    output logic          done
);

    localparam int LEAVES = 1 << $clog2(N_CLASS);

    // Heap layout, node n has children 2n+1 and 2n+2
    class_result_t node [2*LEAVES-1];

    always_comb begin
        for (int i = 0; i < N_CLASS; i++) begin
            node[LEAVES-1+i].class_idx = CLASS_BITS'(i);
            node[LEAVES-1+i].score = scores[i];
        end
        for (int i = N_CLASS; i < LEAVES; i++) begin
            node[LEAVES-1+i].class_idx = CLASS_BITS'(i);
            node[LEAVES-1+i].score = '0; // Padding leaves lose every comparison
        end
        for (int n = LEAVES - 2; n >= 0; n--) begin
            // Left child holds the lower indices and keeps ties
            node[n] = (node[2*n+2].score > node[2*n+1].score) ? node[2*n+2] : node[2*n+1];
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            result <= node[0];
        end
        done <= start;
    end

endmodule

`default_nettype wire

/* verilog/tnn_classifier.sv */
`default_nettype none

module tnn_classifier
    import tnn_cfg_pkg::*;
    import tnn_weights_pkg::*;
#(
    parameter int GROUP = 8
) (
    input  logic          clk,
    input  logic          rst,
    input  feature_vec_t  vec_in,
    input  logic          empty,
    output logic          pop,
    output class_result_t result,
    output logic          result_valid
);

    localparam int N_GROUPS = N_HID / GROUP;
    localparam int GRP_BITS = (N_GROUPS > 1) ? $clog2(N_GROUPS) : 1;
    localparam int HID_IDX_BITS = $clog2(N_HID);

    cls_state_t state;
    logic [GRP_BITS-1:0] grp_cnt;
    logic [HID_IDX_BITS-1:0] grp_base;
    logic last_grp;
    logic decide;
    feature_vec_t vec_q;
    logic [GROUP-1:0] fire;
    score_vec_t scores;

    function automatic logic neuron_fire(input int idx, input feature_vec_t v);
        logic [HSUM_BITS-1:0] psum;
        logic [HSUM_BITS-1:0] nsum;
        logic live;
        psum = '0;
        nsum = '0;
        live = 1'b0;
        for (int f = 0; f < N_FEAT; f++) begin
            if (hid_weight[idx][f] == POS) begin
                psum = psum + HSUM_BITS'(v.feat[f]);
            end else if (hid_weight[idx][f] == NEG) begin
                nsum = nsum + HSUM_BITS'(v.feat[f]);
            end
            live = live | (hid_weight[idx][f] != ZRO);
        end
        return live && (psum >= nsum); // A neuron with no inputs never fires
    endfunction

    // Votes one class collects from the current group of neurons
    function automatic score_t class_gain(input int cls, input int base,
                                          input logic [GROUP-1:0] f);
        score_t gain;
        gain = '0;
        for (int g = 0; g < GROUP; g++) begin
            if ((out_weight[cls][base + g] == POS) && f[g]) begin
                gain = gain + score_t'(1);
            end else if ((out_weight[cls][base + g] == NEG) && !f[g]) begin
                gain = gain + score_t'(1);
            end
        end
        return gain;
    endfunction

    assign pop = (state == CLS_IDLE) && !empty;
    assign decide = (state == CLS_DECIDE);
    assign last_grp = (grp_cnt == GRP_BITS'(N_GROUPS - 1));
    assign grp_base = HID_IDX_BITS'(int'(grp_cnt) * GROUP);

    for (genvar g = 0; g < GROUP; g++) begin : g_neuron
        assign fire[g] = neuron_fire(int'(grp_base) + g, vec_q);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CLS_IDLE;
            grp_cnt <= '0;
        end else begin
            case (state)
                CLS_IDLE: begin
                    if (pop) begin
                        state <= CLS_ACCUM;
                        grp_cnt <= '0;
                    end
                end
                CLS_ACCUM: begin
                    grp_cnt <= grp_cnt + 1'b1;
                    if (last_grp) begin
                        state <= CLS_DECIDE;
                    end
                end
                CLS_DECIDE: state <= CLS_IDLE;
                default: state <= CLS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            vec_q <= vec_in;
            scores <= '0;
        end else if (state == CLS_ACCUM) begin
            for (int c = 0; c < N_CLASS; c++) begin
                scores[c] <= scores[c] + class_gain(c, int'(grp_base), fire);
            end
        end
    end

    argmax argmax_i (
        .clk    (clk),
        .scores (scores),
        .start  (decide),
        .result (result),
        .done   (result_valid)
    );

endmodule

`default_nettype wire

/* verilog/wine_quality_top.sv */
`default_nettype none

module wine_quality_top
    import tnn_cfg_pkg::*;
#(
    parameter int FIFO_DEPTH = 4,
    parameter int GROUP = 8
) (
    input  logic          clk,
    input  logic          rst,
    input  raw_sample_t   sample_in,
    input  logic          sample_valid,
    output class_result_t result,
    output logic          result_valid,
    output logic          overflow
);

    feature_vec_t q_vec;
    logic q_valid;
    feature_vec_t fifo_dout;
    logic fifo_empty;
    logic cls_pop;

    feature_quantizer quant_i (
        .clk          (clk),
        .rst          (rst),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .vec_out      (q_vec),
        .vec_valid    (q_valid)
    );

    vector_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk      (clk),
        .rst      (rst),
        .push     (q_valid),
        .din      (q_vec),
        .pop      (cls_pop),
        .dout     (fifo_dout),
        .empty    (fifo_empty),
        .overflow (overflow)
    );

    tnn_classifier #(
        .GROUP (GROUP)
    ) cls_i (
        .clk          (clk),
        .rst          (rst),
        .vec_in       (fifo_dout),
        .empty        (fifo_empty),
        .pop          (cls_pop),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

`default_nettype wire

/* bench/tnn_model.svh */
`ifndef TNN_MODEL_SVH
`define TNN_MODEL_SVH

// Reference model built from the quantizing and scoring rules
function automatic feature_vec_t model_quantize(input raw_sample_t s);
    feature_vec_t v;
    int d;
    for (int f = 0; f < N_FEAT; f++) begin
        d = int'(s.feat[f]) - int'(feat_offset[f]);
        d = (d < 0) ? 0 : d; // Below the offset saturates to zero
        v.feat[f] = q_feat_t'(d / (1 << (RAW_BITS - Q_BITS)));
    end
    return v;
endfunction

function automatic class_result_t model_classify(input feature_vec_t v);
    int act [N_HID];
    int score [N_CLASS];
    int pos_sum;
    int neg_sum;
    int used;
    int best;
    class_result_t r;
    for (int h = 0; h < N_HID; h++) begin
        pos_sum = 0;
        neg_sum = 0;
        used = 0;
        for (int f = 0; f < N_FEAT; f++) begin
            if (int'(hid_weight[h][f]) > 0) pos_sum = pos_sum + int'(v.feat[f]);
            if (int'(hid_weight[h][f]) < 0) neg_sum = neg_sum + int'(v.feat[f]);
            if (int'(hid_weight[h][f]) != 0) used = used + 1;
        end
        act[h] = (used > 0 && pos_sum >= neg_sum) ? 1 : 0;
    end
    best = 0;
    for (int c = 0; c < N_CLASS; c++) begin
        score[c] = 0;
        for (int h = 0; h < N_HID; h++) begin
            if (int'(out_weight[c][h]) > 0 && act[h] == 1) score[c] = score[c] + 1;
            if (int'(out_weight[c][h]) < 0 && act[h] == 0) score[c] = score[c] + 1;
        end
        if (score[c] > score[best]) best = c; // Strictly greater keeps the lower index
    end
    r.class_idx = CLASS_BITS'(best);
    r.score = score_t'(score[best]);
    return r;
endfunction

`endif

/* bench/tb_wine_quality.sv */
`default_nettype none

module tb_wine_quality
    import tnn_cfg_pkg::*;
    import tnn_weights_pkg::*;
();

    localparam int SEED = 32'hbbd;
    localparam int N_RAND = 100;
    localparam int N_LATE = 50;
    localparam int N_BURST = 12;
    localparam int TOTAL_SAMPLES = N_RAND + 3 + N_BURST + N_LATE;
    localparam int WD_CYCLES = 20 * TOTAL_SAMPLES + 1000;
    localparam int QUIET = 3 * (N_HID / 8 + 2); // Three result latencies without output

    logic clk;
    logic rst;
    raw_sample_t sample_in;
    logic sample_valid;
    class_result_t result;
    logic result_valid;
    logic overflow;

    class_result_t exp_q[$];
    class_result_t burst_q[$];
    int cycle = 0;
    int last_result_cycle = 0;
    int burst_hits;
    int seed_val;
    logic burst_mode;
    logic burst_first;
    logic ovf_check;
    logic ovf_exp;
    raw_sample_t s;

    `include "tnn_model.svh"

    wine_quality_top #(.FIFO_DEPTH(4), .GROUP(8)) dut_i (
        .clk(clk), .rst(rst), .sample_in(sample_in), .sample_valid(sample_valid),
        .result(result), .result_valid(result_valid), .overflow(overflow)
    );

    task automatic fail_run();
        $display("Regression failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_result(input class_result_t exp, input class_result_t got);
        assert (got.class_idx == exp.class_idx) else begin
            $display("[FAIL] result.class_idx expected %h got %h", exp.class_idx, got.class_idx);
            fail_run();
        end
        assert (got.score == exp.score) else begin
            $display("[FAIL] result.score expected %h got %h", exp.score, got.score);
            fail_run();
        end
    endtask

    task automatic match_burst(input class_result_t got);
        assert (burst_q.size() > 0) else begin
            $display("A burst result arrived with no burst prediction left to match");
            fail_run();
        end
        if (burst_first) begin
            compare_result(burst_q[0], got); // The first burst sample is never dropped
            burst_first = 1'b0;
        end else begin
            while (burst_q.size() > 1 && burst_q[0] != got) void'(burst_q.pop_front());
            compare_result(burst_q[0], got);
        end
        void'(burst_q.pop_front());
        burst_hits = burst_hits + 1;
    endtask

    function automatic raw_sample_t rand_sample();
        raw_sample_t r;
        for (int f = 0; f < N_FEAT; f++) r.feat[f] = raw_feat_t'($urandom());
        return r;
    endfunction

    // Called on a falling edge, returns on the next one
    task automatic send_sample(input raw_sample_t smp, input logic to_burst);
        sample_in = smp;
        sample_valid = 1'b1;
        if (to_burst) burst_q.push_back(model_classify(model_quantize(smp)));
        else exp_q.push_back(model_classify(model_quantize(smp)));
        @(negedge clk);
        sample_valid = 1'b0;
    endtask

    task automatic send_spaced(input raw_sample_t smp);
        send_sample(smp, 1'b0);
        repeat (9) @(negedge clk);
    endtask

    task automatic wait_results();
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // Outputs are sampled on the falling edge where they are stable
    always @(negedge clk) begin
        if (!rst && result_valid) begin
            last_result_cycle = cycle;
            if (burst_mode) begin
                match_burst(result);
            end else begin
                assert (exp_q.size() > 0) else begin
                    $display("A result arrived with no prediction pending");
                    fail_run();
                end
                compare_result(exp_q.pop_front(), result);
            end
        end
        if (!rst && ovf_check) begin
            assert (overflow == ovf_exp) else begin
                $display("[FAIL] overflow expected %h got %h", ovf_exp, overflow);
                fail_run();
            end
        end
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("Watchdog timeout, the DUT stopped producing the expected results");
        fail_run();
    end

    initial begin
        seed_val = $urandom(SEED);
        rst = 1'b1;
        sample_in = '0;
        sample_valid = 1'b0;
        burst_mode = 1'b0;
        burst_first = 1'b0;
        burst_hits = 0;
        ovf_check = 1'b0;
        ovf_exp = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        ovf_check = 1'b1;
        repeat (50) begin
            @(negedge clk);
            assert (result_valid == 1'b0) else begin
                $display("[FAIL] result_valid expected %h got %h", 1'b0, result_valid);
                fail_run();
            end
        end
        repeat (N_RAND) send_spaced(rand_sample());
        wait_results();
        s = '0;
        send_spaced(s);
        s = '1;
        send_spaced(s);
        for (int f = 0; f < N_FEAT; f++) s.feat[f] = feat_offset[f];
        send_spaced(s);
        wait_results();
        ovf_check = 1'b0;
        burst_mode = 1'b1;
        burst_first = 1'b1;
        repeat (N_BURST) send_sample(rand_sample(), 1'b1);
        while (burst_hits == 0 || cycle - last_result_cycle < QUIET) @(negedge clk);
        assert (burst_hits >= 5 && burst_hits <= N_BURST) else begin
            $display("Burst delivered %0d results, outside the range 5 to 12", burst_hits);
            fail_run();
        end
        burst_mode = 1'b0;
        burst_q.delete();
        ovf_exp = 1'b1; // Sticky after the burst
        ovf_check = 1'b1;
        repeat (N_LATE) send_spaced(rand_sample());
        wait_results();
        ovf_check = 1'b0;
        rst = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (overflow == 1'b0) else begin
            $display("[FAIL] overflow expected %h got %h", 1'b0, overflow);
            fail_run();
        end
        if (exp_q.size() == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("%0d predictions never received a result", exp_q.size());
            fail_run();
        end
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+bench
verilog/tnn_cfg_pkg.sv
verilog/tnn_weights_pkg.sv
verilog/feature_quantizer.sv
verilog/vector_fifo.sv
verilog/argmax.sv
verilog/tnn_classifier.sv
verilog/wine_quality_top.sv
bench/tb_wine_quality.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_wine_quality
RTL_TOP ?= wine_quality_top
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
SEED_ARGS ?= +verilator+seed+3005
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

RTL_FILES := $(filter verilog/%.sv,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SEED_ARGS)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
